//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --assert -Wno-fatal -j 0
TOP = fpAddSubTb
FILELIST = project.f
OBJDIR = obj_dir
PASS_MSG = Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- bench/fpAddSubTb.sv
`timescale 1ns/10ps

module fpAddSubTb;
	import fpAddPkg::*;

	localparam int clkPeriod = 40;
	localparam int maxGap = 3;                            // Longest idle gap in the throughput run
	localparam int totalOps = 200 + 200 + 80 + 80 + 20 + 100;
	localparam int watchdogCycles = totalOps * (maxGap + 1) + 20;

	logic clk;
	logic rstN;
	logic inValid;
	logic [dataWidth-1:0] opA;
	logic [dataWidth-1:0] opB;
	addOpT op;
	logic outValid;
	logic [dataWidth-1:0] result;
	logic overflow;

	integer seed = 32'h3bc;
	int cycleCnt = 0;                                     // Counts falling edges
	int errCount = 0;
	int checkCount = 0;

	// Scoreboard, one entry per accepted operation
	logic [dataWidth-1:0] expResQ[$];
	logic expOvfQ[$];
	int issueQ[$];

	logic [dataWidth-1:0] wantRes;
	logic wantOvf;
	int issued;

	fpAddSub DUT (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.opA(opA),
		.opB(opB),
		.op(op),
		.outValid(outValid),
		.result(result),
		.overflow(overflow)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	function automatic int randRange(input int lo, input int hi);
		return lo + int'({$random(seed)} % (hi - lo + 1));
	endfunction

	function automatic logic [dataWidth-1:0] randOperand(input int expLo, input int expHi);
		return {1'(randRange(0, 1)), expWidth'(randRange(expLo, expHi)),
			manWidth'(randRange(0, (1 << manWidth) - 1))};
	endfunction

	function automatic logic [dataWidth-1:0] zeroOperand();
		return {1'(randRange(0, 1)), (dataWidth - 1)'(0)};  // Either signed zero
	endfunction

	// Reference: truncating align, effective op, normalize, then pack
	task automatic modelAddSub(input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b,
			input addOpT o, output logic [dataWidth-1:0] res, output logic ovf);
		logic signA;
		logic signB;
		logic bigSign;
		int bigExp;
		int bigMan;
		int smallExp;
		int smallMan;
		int aligned;
		int sum;
		int e;
		signA = a[dataWidth-1];
		signB = b[dataWidth-1] ^ (o == opSub);             // Subtract flips B
		if (a[dataWidth-2:0] >= b[dataWidth-2:0]) begin
			bigSign = signA;
			bigExp = int'(a[dataWidth-2 -: expWidth]);
			bigMan = int'(a[manWidth-1:0]);
			smallExp = int'(b[dataWidth-2 -: expWidth]);
			smallMan = int'(b[manWidth-1:0]);
		end else begin
			bigSign = signB;
			bigExp = int'(b[dataWidth-2 -: expWidth]);
			bigMan = int'(b[manWidth-1:0]);
			smallExp = int'(a[dataWidth-2 -: expWidth]);
			smallMan = int'(a[manWidth-1:0]);
		end
		bigMan = (bigExp == 0) ? 0 : bigMan + (1 << manWidth); // Flush or hidden one
		if (smallExp == 0 || bigExp - smallExp >= manWidth + 1)
			aligned = 0;                                   // Shifted fully out
		else
			aligned = (smallMan + (1 << manWidth)) >> (bigExp - smallExp);
		sum = (signA ^ signB) ? bigMan - aligned : bigMan + aligned;
		e = bigExp;
		if (sum >= (2 << manWidth)) begin
			sum = sum >> 1;                                // Carry, LSB dropped
			e = e + 1;
		end else if (sum != 0) begin
			while (sum < (1 << manWidth)) begin
				sum = sum << 1;
				e = e - 1;
			end
		end
		if (sum == 0 || e <= 0) begin
			res = '0;                                      // Cancellation or underflow
			ovf = 1'b0;
		end else if (e >= expMax) begin
			res = {bigSign, expWidth'(expMax), manWidth'(0)};
			ovf = 1'b1;
		end else begin
			res = {bigSign, expWidth'(e), manWidth'(sum)};
			ovf = 1'b0;
		end
	endtask

	task automatic sendOp(input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b,
			input addOpT o);
		logic [dataWidth-1:0] r;
		logic v;
		@(posedge clk);
		inValid <= 1'b1;
		opA <= a;
		opB <= b;
		op <= o;
		modelAddSub(a, b, o, r, v);
		expResQ.push_back(r);
		expOvfQ.push_back(v);
		issueQ.push_back(cycleCnt + 1);                   // Falling edge where it is visible
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(posedge clk);
			inValid <= 1'b0;
		end
	endtask

	// Scoreboard side, sampled mid-cycle
	always @(negedge clk) begin
		cycleCnt++;
		if (rstN === 1'b1 && outValid === 1'b1) begin
			if (expResQ.size() == 0) begin
				$display("ERROR at %0t: outValid high with no operation outstanding", $time);
				errCount++;
			end else begin
				wantRes = expResQ.pop_front();
				wantOvf = expOvfQ.pop_front();
				issued = issueQ.pop_front();
				checkCount++;
				assert (result === wantRes) else begin
					$display("CHECK FAILED at %0t: result got %h expected %h",
						$time, result, wantRes);
					errCount++;
				end
				assert (overflow === wantOvf) else begin
					$display("CHECK FAILED at %0t: overflow got %b expected %b",
						$time, overflow, wantOvf);
					errCount++;
				end
				assert (cycleCnt - issued == 3) else begin
					$display("CHECK FAILED at %0t: latency got %0d expected 3",
						$time, cycleCnt - issued);
					errCount++;
				end
			end
		end
	end

	initial begin
		int ea;
		int eb;
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		logic [dataWidth-1:0] tmp;
		rstN = 1'b0;
		inValid = 1'b0;
		opA = '0;
		opB = '0;
		op = opAdd;
		repeat (4) @(posedge clk);                        // Reset seen on four edges
		rstN <= 1'b1;

		// Random adds, occasional zero operand
		repeat (200) begin
			a = (randRange(0, 15) == 0) ? zeroOperand() : randOperand(1, 254);
			b = (randRange(0, 15) == 0) ? zeroOperand() : randOperand(1, 254);
			sendOp(a, b, opAdd);
		end

		// Random subtracts, half with nearby exponents for deep cancellation
		repeat (200) begin
			a = randOperand(1, 254);
			if (randRange(0, 1) == 1) begin
				ea = int'(a[dataWidth-2 -: expWidth]);
				eb = ea + randRange(-2, 2);
				eb = (eb < 1) ? 1 : (eb > 254) ? 254 : eb;
				b = {1'(randRange(0, 1)), expWidth'(eb), manWidth'(randRange(0, 127))};
			end else begin
				b = randOperand(1, 254);
			end
			sendOp(a, b, opSub);
		end

		// Zero handling
		repeat (20) begin
			a = randOperand(1, 254);
			sendOp(a, a, opSub);                            // Exact cancellation
			sendOp(a, zeroOperand(), opAdd);
			sendOp(zeroOperand(), a, opAdd);
			sendOp(zeroOperand(), zeroOperand(), opAdd);
		end

		// Exponent gap of 8 or more, coarse zeroing path
		repeat (40) begin
			ea = randRange(9, 254);
			eb = randRange(1, ea - 8);
			a = {1'(randRange(0, 1)), expWidth'(ea), manWidth'(randRange(0, 127))};
			b = {1'(randRange(0, 1)), expWidth'(eb), manWidth'(randRange(0, 127))};
			if (randRange(0, 1) == 1) begin
				tmp = a;                                   // Larger one on the B side
				a = b;
				b = tmp;
			end
			sendOp(a, b, opAdd);
			sendOp(a, b, opSub);
		end

		// Same sign at exponent 254 always carries into infinity
		repeat (20) begin
			a = randOperand(254, 254);
			b = {a[dataWidth-1], expWidth'(254), manWidth'(randRange(0, 127))};
			sendOp(a, b, opAdd);
		end

		// Back-to-back with random idle gaps
		repeat (100) begin
			sendOp(randOperand(1, 254), randOperand(1, 254), addOpT'(randRange(0, 1)));
			if (randRange(0, 1) == 1) idleCycles(randRange(1, maxGap));
		end

		idleCycles(1);
		for (int i = 0; i < 10 && expResQ.size() > 0; i++) @(posedge clk);
		repeat (4) @(posedge clk);                        // Catch stray outValid
		if (expResQ.size() != 0) begin
			$display("ERROR: %0d operations never produced a result", expResQ.size());
			errCount += expResQ.size();
		end

		$display("Checks run: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// Watchdog sized from the op count with worst-case gaps
	initial begin
		#(watchdogCycles * clkPeriod);
		$display("ERROR: simulation timed out after %0d cycles", watchdogCycles);
		$display("Verification failed");
		$finish;
	end

endmodule

//--- bench/fpAddSub_properties.sv
`timescale 1ns/10ps

module fpAddSubProperties (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input logic outValid,
	input logic [fpAddPkg::dataWidth-1:0] result,
	input logic overflow
);
	import fpAddPkg::*;

	// Valid pipe cleared by reset
	assert property (@(posedge clk) !rstN |=> !outValid)
		else $error("outValid high during or right after reset");

	// Fixed three-cycle latency once reset has been gone long enough
	assert property (@(posedge clk)
		($past(rstN, 3) && $past(rstN, 2) && $past(rstN)) |-> outValid == $past(inValid, 3))
		else $error("outValid does not follow inValid by three cycles");

	assert property (@(posedge clk) disable iff (!rstN) outValid |-> !$isunknown(result))
		else $error("result has unknown bits while outValid is high");

	// Overflow only ever comes with an infinity encoding
	assert property (@(posedge clk) disable iff (!rstN)
		overflow |-> result[dataWidth-2:0] == {expWidth'(expMax), manWidth'(0)})
		else $error("overflow set without an infinity result");

endmodule

bind fpAddSub fpAddSubProperties props (.*);

//--- design/fpAddAlignCoarse.sv
`timescale 1ns/10ps

module fpAddAlignCoarse (
	input logic [fpAddPkg::manWidth-1:0] MminP,    // Smaller mantissa, no hidden bit
	input logic [fpAddPkg::shiftHiWidth-1:0] shift, // Exponent diff bits 7..2
	output logic [fpAddPkg::manWidth:0] Mmin        // Coarsely aligned mantissa
);
	import fpAddPkg::*;

	logic [manWidth:0] fullMan;

	// Hidden one back in front
	assign fullMan = {1'b1, MminP};

	// Eight mantissa bits total, so any shift of 8 or more leaves nothing
	always_comb begin
		if (|shift[shiftHiWidth-1:1]) begin
			Mmin = '0;            // Shifted fully out
		end else if (shift[0]) begin
			Mmin = fullMan >> 4;  // Zero fill from the top
		end else begin
			Mmin = fullMan;
		end
	end

endmodule

//--- design/fpAddExecute.sv
`timescale 1ns/10ps

module fpAddExecute (
	input logic [fpAddPkg::manWidth:0] bigMan,     // Larger mantissa with hidden bit
	input logic [fpAddPkg::manWidth:0] alignedMan, // From the coarse shifter
	input logic [1:0] fineShift,                    // Exponent diff bits 1..0
	input logic effSub,
	output logic [fpAddPkg::manWidth+1:0] sumMan    // Top bit is the carry
);
	import fpAddPkg::*;

	logic [manWidth:0] shiftedMan;
	logic [manWidth+1:0] bigExt;
	logic [manWidth+1:0] smallExt;

	// Remaining 0..3 bits of alignment, low bits dropped
	assign shiftedMan = alignedMan >> fineShift;

	// One spare bit for the carry out of an add
	assign bigExt = {1'b0, bigMan};
	assign smallExt = {1'b0, shiftedMan};

	// Big side was picked by magnitude so subtract never wraps
	assign sumMan = effSub ? bigExt - smallExt : bigExt + smallExt;

endmodule

//--- design/fpAddNormalize.sv
`timescale 1ns/10ps

module fpAddNormalize (
	input logic sign,
	input logic [fpAddPkg::expWidth-1:0] bigExp,
	input logic [fpAddPkg::manWidth+1:0] sumMan,
	output logic [fpAddPkg::dataWidth-1:0] result,
	output logic overflow
);
	import fpAddPkg::*;

	logic [expWidth-1:0] lzCount;
	logic [manWidth:0] normMan;   // Hidden bit at the top once normalized
	logic [expWidth:0] expWork;   // Extra bit catches the carry increment
	logic underflow;

	// Leading zeros of the 8-bit magnitude, 8 when all clear
	function automatic logic [expWidth-1:0] countLz(input logic [manWidth:0] v);
		logic [expWidth-1:0] n;
		n = expWidth'(manWidth + 1);
		for (int i = 0; i <= manWidth; i++) begin
			if (v[i]) n = expWidth'(manWidth - i); // Highest set bit wins
		end
		return n;
	endfunction

	assign lzCount = countLz(sumMan[manWidth:0]);

	always_comb begin
		if (sumMan[manWidth+1]) begin
			// Carry out, drop the LSB
			normMan = sumMan[manWidth+1:1];
			expWork = {1'b0, bigExp} + (expWidth + 1)'(1);
			underflow = 1'b0;
		end else begin
			normMan = sumMan[manWidth:0] << lzCount;
			expWork = {1'b0, bigExp} - {1'b0, lzCount};
			underflow = (lzCount >= bigExp); // Exponent would land at or below zero
		end

		// Packing, zero wins over everything
		if (sumMan == '0 || underflow) begin
			result = '0;                                        // Always +0
			overflow = 1'b0;
		end else if (expWork >= (expWidth + 1)'(expMax)) begin
			result = {sign, expWidth'(expMax), manWidth'(0)};   // Signed infinity
			overflow = 1'b1;
		end else begin
			result = {sign, expWork[expWidth-1:0], normMan[manWidth-1:0]};
			overflow = 1'b0;
		end
	end

endmodule

//--- design/fpAddPkg.sv
package fpAddPkg;

	// bfloat16 field widths
	localparam int expWidth = 8;                       // Exponent field
	localparam int manWidth = 7;                       // Stored mantissa, no hidden bit
	localparam int dataWidth = 1 + expWidth + manWidth; // Sign, exponent, mantissa

	// Coarse shifter only sees diff bits 7..2, the low two go to the fine shift
	localparam int shiftHiWidth = expWidth - 2;

	// All-ones exponent, infinity
	localparam int expMax = 2 ** expWidth - 1;

	// Opcode, one bit on the port
	typedef enum logic {
		opAdd = 1'b0, // A + B
		opSub = 1'b1  // A - B
	} addOpT;

endpackage

//--- design/fpAddPrealign.sv
`timescale 1ns/10ps

module fpAddPrealign (
	input logic [fpAddPkg::dataWidth-1:0] opA,
	input logic [fpAddPkg::dataWidth-1:0] opB,
	input fpAddPkg::addOpT op,
	output logic bigSign,
	output logic [fpAddPkg::expWidth-1:0] bigExp,
	output logic [fpAddPkg::manWidth:0] bigMan,     // Hidden bit included
	output logic [fpAddPkg::manWidth-1:0] smallManP, // Hidden bit added later
	output logic [fpAddPkg::expWidth-1:0] expDiff,
	output logic effSub
);
	import fpAddPkg::*;

	logic signA;
	logic signB;                      // Sign of B after the opcode
	logic [expWidth-1:0] expA;
	logic [expWidth-1:0] expB;
	logic [manWidth-1:0] manA;
	logic [manWidth-1:0] manB;
	logic aIsBig;
	logic [expWidth-1:0] smallExp;
	logic [manWidth-1:0] bigManRaw;

	// Field split
	assign signA = opA[dataWidth-1];
	assign expA = opA[dataWidth-2 -: expWidth];
	assign manA = opA[manWidth-1:0];
	assign expB = opB[dataWidth-2 -: expWidth];
	assign manB = opB[manWidth-1:0];

	// Subtract is add with B negated
	assign signB = opB[dataWidth-1] ^ (op == opSub);

	// Exponent sits above mantissa, so one compare covers both
	assign aIsBig = (opA[dataWidth-2:0] >= opB[dataWidth-2:0]); // Tie goes to A

	always_comb begin
		if (aIsBig) begin
			bigSign = signA;
			bigExp = expA;
			bigManRaw = manA;
			smallExp = expB;
			smallManP = manB;
		end else begin
			bigSign = signB;
			bigExp = expB;
			bigManRaw = manB;
			smallExp = expA;
			smallManP = manA;
		end
	end

	// Zero or denormal large operand flushes to a zero magnitude
	assign bigMan = (bigExp != '0) ? {1'b1, bigManRaw} : '0;

	// Zero exponent on the small side forces a full-width clear downstream
	assign expDiff = (smallExp == '0) ? expWidth'(expMax) : bigExp - smallExp;

	// Opposite signs after the opcode means a true subtract
	assign effSub = signA ^ signB;

endmodule

//--- design/fpAddSub.sv
`timescale 1ns/10ps

module fpAddSub (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input logic [fpAddPkg::dataWidth-1:0] opA,
	input logic [fpAddPkg::dataWidth-1:0] opB,
	input fpAddPkg::addOpT op,
	output logic outValid,
	output logic [fpAddPkg::dataWidth-1:0] result, // Stale while outValid is low
	output logic overflow
);
	import fpAddPkg::*;

	logic [2:0] validPipe;            // One bit per stage register

	// Prealign outputs
	logic preSign;
	logic [expWidth-1:0] preExp;
	logic [manWidth:0] preBigMan;
	logic [manWidth-1:0] preSmallManP;
	logic [expWidth-1:0] preDiff;
	logic preEffSub;

	// Stage 1 bank
	logic s1Sign;
	logic [expWidth-1:0] s1Exp;
	logic [manWidth:0] s1BigMan;
	logic [manWidth-1:0] s1SmallManP;
	logic [expWidth-1:0] s1ExpDiff;
	logic s1EffSub;

	// Stage 2 logic and bank
	logic [manWidth:0] alignedMan;
	logic [manWidth+1:0] sumMan;
	logic s2Sign;
	logic [expWidth-1:0] s2Exp;
	logic [manWidth+1:0] s2SumMan;

	// Normalize outputs
	logic [dataWidth-1:0] normResult;
	logic normOverflow;

	fpAddPrealign prealign (
		.opA(opA),
		.opB(opB),
		.op(op),
		.bigSign(preSign),
		.bigExp(preExp),
		.bigMan(preBigMan),
		.smallManP(preSmallManP),
		.expDiff(preDiff),
		.effSub(preEffSub)
	);

	always_ff @(posedge clk) begin
		if (inValid) begin
			s1Sign <= preSign;
			s1Exp <= preExp;
			s1BigMan <= preBigMan;
			s1SmallManP <= preSmallManP;
			s1ExpDiff <= preDiff;
			s1EffSub <= preEffSub;
		end
	end

	// Coarse shift takes the upper diff bits
	fpAddAlignCoarse alignCoarse (
		.MminP(s1SmallManP),
		.shift(s1ExpDiff[expWidth-1:2]),
		.Mmin(alignedMan)
	);

	fpAddExecute execute (
		.bigMan(s1BigMan),
		.alignedMan(alignedMan),
		.fineShift(s1ExpDiff[1:0]), // Low two bits finish the alignment
		.effSub(s1EffSub),
		.sumMan(sumMan)
	);

	always_ff @(posedge clk) begin
		if (validPipe[0]) begin
			s2Sign <= s1Sign;       // Result sign follows the larger operand
			s2Exp <= s1Exp;
			s2SumMan <= sumMan;
		end
	end

	fpAddNormalize normalize (
		.sign(s2Sign),
		.bigExp(s2Exp),
		.sumMan(s2SumMan),
		.result(normResult),
		.overflow(normOverflow)
	);

	always_ff @(posedge clk) begin
		if (validPipe[1]) result <= normResult;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			overflow <= 1'b0;
		end else if (validPipe[1]) begin
			overflow <= normOverflow;
		end
	end

	// Valid strobe rides alongside the data, no stalls
	always_ff @(posedge clk) begin
		if (!rstN) begin
			validPipe <= '0;
		end else begin
			validPipe <= {validPipe[1:0], inValid};
		end
	end

	assign outValid = validPipe[2];

endmodule

//--- project.f
design/fpAddPkg.sv
design/fpAddPrealign.sv
design/fpAddAlignCoarse.sv
design/fpAddExecute.sv
design/fpAddNormalize.sv
design/fpAddSub.sv
bench/fpAddSub_properties.sv
bench/fpAddSubTb.sv
